// ==== nccLog.f ====
+incdir+include
rtl/nccPkg.sv
rtl/logDecode.sv
rtl/logTap.sv
rtl/tapArray.sv
rtl/scoreResult.sv
rtl/nccLogTop.sv
sim/nccLogTb.sv

// ==== Makefile ====
OBJ = obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f nccLog.f --top-module nccLogTb \
		-Mdir $(OBJ) -o nccLogSim
	./$(OBJ)/nccLogSim

clean:
	rm -rf $(OBJ)

// ==== include/nccLogModel.svh ====
`ifndef NCC_LOG_MODEL_SVH
`define NCC_LOG_MODEL_SVH

// One xorshift32 step.
function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// Log domain product of two unsigned magnitudes.
function automatic int mitchellProduct(input int a, input int b);
	int ea;
	int eb;
	int fa;
	int fb;
	int fs;
	int e;
	if (a == 0 || b == 0) begin
		return 0;
	end
	ea = $clog2(a + 1) - 1;
	eb = $clog2(b + 1) - 1;
	// Bits under the leading one, truncated to FracBits.
	fa = ((a << nccPkg::FracBits) >> ea) & ((1 << nccPkg::FracBits) - 1);
	fb = ((b << nccPkg::FracBits) >> eb) & ((1 << nccPkg::FracBits) - 1);
	fs = fa + fb;
	e = ea + eb;
	if (fs >= (1 << nccPkg::FracBits)) begin
		e = e + 1;
		fs = fs - (1 << nccPkg::FracBits);
	end
	return (1 << e) + ((fs << e) >> nccPkg::FracBits);
endfunction

// Score from the newest history entries.
// Index 0 of each queue is the most recent beat.
// Descriptor entries are signed values.
function automatic int scoreModel(input int descHist[$], input int winHist[$],
		input int numTaps);
	int total;
	int d;
	int w;
	int p;
	total = 0;
	for (int i = 0; i < numTaps; i++) begin
		// A tap not loaded since reset holds an all zero log word and acts as 1.
		d = (i < descHist.size()) ? descHist[i] : 1;
		w = (i < winHist.size()) ? winHist[i] : 1;
		p = mitchellProduct((d < 0) ? -d : d, w);
		total = total + ((d < 0) ? -p : p);
	end
	return total;
endfunction

`endif

// ==== sim/nccLogTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nccLogModel.svh"

module nccLogTb;

	localparam int NumTaps = 8;
	localparam int ScoreBits = 17 + $clog2(NumTaps);

	logic clk;
	logic rst;
	nccPkg::inBeat_t inBeat;
	logic inValid;
	logic inReady;
	logic signed [ScoreBits-1:0] score;
	logic scoreValid;
	logic scoreReady;

	// Expected score FIFO, written on window acceptance.
	int expMem [0:2047];
	// Exact integer product sums, same slots as expMem.
	int exactMem [0:2047];
	int wrPtr;
	int rdPtr;
	int expHead;
	int exactHead;
	// Signed descriptor and window history, newest first.
	int descHist[$];
	int winHist[$];
	int winCount;
	logic expectScore;
	logic [31:0] rngState;
	logic readyRandom;
	logic latencyOn;
	logic exactOn;
	int beatsSent;
	int cycles;
	string testName;

	nccLogTop #(.NumTaps(NumTaps)) uut (.clk, .rst, .inBeat, .inValid, .inReady,
		.score, .scoreValid, .scoreReady);

	always #2 clk = ~clk;

	assign expHead = expMem[rdPtr];
	assign exactHead = exactMem[rdPtr];
	assign expectScore = !inBeat.isDesc && (winCount >= NumTaps - 1);

	task automatic nextRand(output logic [31:0] r);
		rngState = xorshift32(rngState);
		r = rngState;
	endtask

	// Plain integer sum of products over the taps.
	function automatic int trueScore(input int descs[$], input int wins[$]);
		int total;
		total = 0;
		for (int i = 0; i < NumTaps; i++) begin
			total = total + descs[i] * wins[i];
		end
		return total;
	endfunction

	// ####################################################################
	// Reference model
	// ####################################################################

	always @(posedge clk) begin
		if (!rst && inValid && inReady) begin
			if (inBeat.isDesc) begin
				descHist.push_front(inBeat.payload.desc.neg ?
					-int'(inBeat.payload.desc.mag) : int'(inBeat.payload.desc.mag));
				if (descHist.size() > NumTaps) void'(descHist.pop_back());
				winCount <= 0;
			end else begin
				winHist.push_front(int'(inBeat.payload.win));
				if (winHist.size() > NumTaps) void'(winHist.pop_back());
				if (winCount >= NumTaps - 1) begin
					expMem[wrPtr] <= scoreModel(descHist, winHist, NumTaps);
					exactMem[wrPtr] <= trueScore(descHist, winHist);
					wrPtr <= wrPtr + 1;
				end
				if (winCount < NumTaps) winCount <= winCount + 1;
			end
		end
		if (!rst && scoreValid && scoreReady) begin
			rdPtr <= rdPtr + 1;
		end
	end

	// ####################################################################
	// Checks
	// ####################################################################

	// Ready comes up and nothing is valid right out of reset.
	assert property (@(posedge clk) $fell(rst) |-> !scoreValid && inReady)
	else begin
		$display("Outputs were wrong right after reset");
		$display("TESTBENCH FAILED");
		$fatal(1);
	end

	assert property (@(posedge clk) disable iff (rst) scoreValid |-> rdPtr != wrPtr)
	else begin
		$display("A score appeared that the fill rule does not allow in %s", testName);
		$display("TESTBENCH FAILED");
		$fatal(1);
	end

	assert property (@(posedge clk) disable iff (rst)
		scoreValid && scoreReady |-> $signed(score) == expHead)
	else begin
		$display("Fail %s expected %0d actual %0d", testName, $sampled(expHead),
			$sampled($signed(score)));
		$display("TESTBENCH FAILED");
		$fatal(1);
	end

	// Powers of two must also equal true multiplication.
	assert property (@(posedge clk) disable iff (rst)
		exactOn && scoreValid && scoreReady |-> $signed(score) == exactHead)
	else begin
		$display("Fail %s expected %0d actual %0d", testName, $sampled(exactHead),
			$sampled($signed(score)));
		$display("TESTBENCH FAILED");
		$fatal(1);
	end

	// Held score must not move while the consumer stalls.
	assert property (@(posedge clk) disable iff (rst)
		scoreValid && !scoreReady |=> scoreValid && $stable(score))
	else begin
		$display("Score changed or dropped while stalled in %s", testName);
		$display("TESTBENCH FAILED");
		$fatal(1);
	end

	assert property (@(posedge clk) disable iff (rst)
		latencyOn && inValid && inReady && expectScore |-> ##3 scoreValid)
	else begin
		$display("Score did not arrive 3 cycles after its window beat in %s", testName);
		$display("TESTBENCH FAILED");
		$fatal(1);
	end

	// Consumer ready, random or held high.
	always @(posedge clk) begin
		logic [31:0] r;
		logic readyNext;
		nextRand(r);
		readyNext = readyRandom ? r[7] : 1'b1;
		#0.5;
		scoreReady = readyNext;
	end

	// Watchdog scaled by the beats sent so far.
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > 40 * beatsSent + 200) begin
			$display("Watchdog expired, the run stopped making progress");
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	end

	// ####################################################################
	// Stimulus
	// ####################################################################

	// Holds the beat until the DUT takes it.
	task automatic sendBeat(input logic isDesc, input logic [7:0] data);
		logic taken;
		inBeat.isDesc = isDesc;
		inBeat.payload.win = data;
		inValid = 1'b1;
		beatsSent = beatsSent + 1;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = inReady;
			@(posedge clk);
			#0.5;
		end
		inValid = 1'b0;
	endtask

	task automatic randomBeat(input logic isDesc, input logic gaps);
		logic [31:0] r;
		logic [7:0] data;
		nextRand(r);
		data = (r[11:8] == 4'd0) ? 8'd0 : r[7:0];
		if (gaps && r[15:13] == 3'd0) begin
			@(posedge clk);
			#0.5;
		end
		sendBeat(isDesc, data);
	endtask

	task automatic drainScores();
		while (rdPtr != wrPtr) begin
			@(posedge clk);
		end
		@(posedge clk);
		#0.5;
	endtask

	initial begin
		clk = 0;
		rst = 1;
		inBeat = '0;
		inValid = 0;
		scoreReady = 1;
		rngState = 32'hd008_6260;
		readyRandom = 0;
		latencyOn = 0;
		exactOn = 0;
		wrPtr = 0;
		rdPtr = 0;
		winCount = 0;
		beatsSent = 0;
		cycles = 0;
		testName = "reset";
		repeat (3) @(posedge clk);
		#0.5;
		rst = 0;
		@(posedge clk);
		#0.5;

		// Powers of two multiply exactly in the log domain.
		testName = "powers";
		exactOn = 1;
		for (int i = 0; i < NumTaps; i++) sendBeat(1'b1, 8'(1 << (i % 7)));
		for (int i = 0; i < NumTaps + 4; i++) sendBeat(1'b0, 8'(1 << (i % 8)));
		drainScores();
		exactOn = 0;

		// Back to back beats, scores 3 cycles after acceptance.
		testName = "random latency";
		latencyOn = 1;
		for (int k = 0; k < 6; k++) begin
			for (int i = 0; i < NumTaps; i++) randomBeat(1'b1, 1'b0);
			for (int i = 0; i < 20; i++) randomBeat(1'b0, 1'b0);
		end
		drainScores();
		latencyOn = 0;

		// A descriptor beat mid-stream restarts the window count.
		testName = "fill rule";
		for (int i = 0; i < NumTaps; i++) randomBeat(1'b1, 1'b0);
		for (int i = 0; i < 5; i++) randomBeat(1'b0, 1'b0);
		randomBeat(1'b1, 1'b0);
		for (int i = 0; i < NumTaps + 3; i++) randomBeat(1'b0, 1'b0);
		drainScores();

		// Random stalls on the output side.
		testName = "back-pressure";
		readyRandom = 1;
		for (int k = 0; k < 5; k++) begin
			randomBeat(1'b1, 1'b1);
			for (int i = 0; i < 40; i++) randomBeat(1'b0, 1'b1);
		end
		drainScores();
		readyRandom = 0;
		repeat (5) @(posedge clk);

		if (rdPtr == wrPtr) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("Expected scores never arrived");
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/nccLogTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module nccLogTop #(
	parameter int NumTaps = 8,
	localparam int ScoreBits = 17 + $clog2(NumTaps)
) (
	input logic clk,
	input logic rst,
	input nccPkg::inBeat_t inBeat,
	input logic inValid,
	output logic inReady,
	output logic signed [ScoreBits-1:0] score,
	output logic scoreValid,
	input logic scoreReady
);

	// Global pipeline enable.
	logic advance;
	// Decode to execute.
	nccPkg::decoded_t dec;
	// Execute to result.
	logic signed [ScoreBits-1:0] sum;
	logic sumValid;

	// ####################################################################
	// Stall control
	// ####################################################################

	// All stages move together.
	// They stop only while a score is held back.
	assign advance = !scoreValid || scoreReady;
	assign inReady = advance;

	// ####################################################################
	// Stages
	// ####################################################################

	// Decode.
	logDecode decode (.clk, .rst, .advance, .inBeat, .inValid, .dec);

	// Execute.
	tapArray #(
		.NumTaps(NumTaps)
	) execute (.clk, .rst, .advance, .dec, .sum, .sumValid);

	// Result.
	scoreResult #(
		.NumTaps(NumTaps)
	) result (.clk, .rst, .advance, .sum, .sumValid, .score, .scoreValid);

endmodule

`default_nettype wire

// ==== rtl/scoreResult.sv ====
`timescale 1ns/1ps
`default_nettype none

module scoreResult #(
	parameter int NumTaps = 8,
	localparam int ScoreBits = 17 + $clog2(NumTaps)
) (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic signed [ScoreBits-1:0] sum,
	input logic sumValid,
	output logic signed [ScoreBits-1:0] score,
	output logic scoreValid
);

	// ####################################################################
	// Output register
	// ####################################################################

	// advance is low only when a score waits on a stalled consumer.
	// The held score therefore stays put until it is taken.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			score <= '0;
		end else if (advance) begin
			score <= sum;
		end
	end

	// Valid flag of the output stream.
	// Cleared on a transfer unless a new sum arrives.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			scoreValid <= 1'b0;
		end else if (advance) begin
			scoreValid <= sumValid;
		end
	end

	// ####################################################################
	// Handshake check
	// ####################################################################

	// A stalled score stays valid and unchanged.
	assert property (@(posedge clk) disable iff (rst)
		scoreValid && !advance |=> scoreValid && $stable(score));

endmodule

`default_nettype wire

// ==== rtl/tapArray.sv ====
`timescale 1ns/1ps
`default_nettype none

module tapArray #(
	parameter int NumTaps = 8,
	localparam int ScoreBits = 17 + $clog2(NumTaps)
) (
	input logic clk,
	input logic rst,
	input logic advance,
	input nccPkg::decoded_t dec,
	output logic signed [ScoreBits-1:0] sum,
	output logic sumValid
);

	// Fill counter counts up to NumTaps inclusive.
	localparam int CntBits = $clog2(NumTaps) + 1;
	localparam logic [CntBits-1:0] FullCount = CntBits'(NumTaps);

	logic shiftDesc;
	logic shiftWin;
	logic [CntBits-1:0] fill;
	nccPkg::tapWord_t head;
	nccPkg::tapWord_t descFeed [NumTaps];
	nccPkg::tapWord_t winFeed [NumTaps];
	nccPkg::tapWord_t descLink [NumTaps];
	nccPkg::tapWord_t winLink [NumTaps];
	logic signed [16:0] terms [NumTaps];

	// Each chain shifts only on its own beat kind.
	assign shiftDesc = advance && dec.valid && dec.isDesc;
	assign shiftWin = advance && dec.valid && !dec.isDesc;

	// Head of both chains.
	assign head.neg = dec.neg;
	assign head.lw = dec.lw;

	// ####################################################################
	// Tap chain
	// ####################################################################

	for (genvar i = 0; i < NumTaps; i++) begin : gTap
		if (i == 0) begin : gFirst
			assign descFeed[i] = head;
			assign winFeed[i] = head;
		end else begin : gNext
			assign descFeed[i] = descLink[i-1];
			assign winFeed[i] = winLink[i-1];
		end
		logTap tap (.clk, .rst, .shiftDesc, .shiftWin,
			.descIn(descFeed[i]), .winIn(winFeed[i]),
			.descOut(descLink[i]), .winOut(winLink[i]), .term(terms[i]));
	end

	// Window fill count.
	// sumValid follows the shift so it matches the new tap contents.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fill <= '0;
			sumValid <= 1'b0;
		end else if (advance) begin
			sumValid <= shiftWin && (fill >= FullCount - 1'b1);
			if (shiftDesc) begin
				fill <= '0;
			end else if (shiftWin && fill != FullCount) begin
				fill <= fill + 1'b1;
			end
		end
	end

	// Signed adder tree over the taps.
	always_comb begin
		sum = '0;
		for (int i = 0; i < NumTaps; i++) begin
			sum = sum + ScoreBits'(terms[i]);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/logTap.sv ====
`timescale 1ns/1ps
`default_nettype none

module logTap (
	input logic clk,
	input logic rst,
	input logic shiftDesc,
	input logic shiftWin,
	input nccPkg::tapWord_t descIn,
	input nccPkg::tapWord_t winIn,
	output nccPkg::tapWord_t descOut,
	output nccPkg::tapWord_t winOut,
	output logic signed [16:0] term
);

	// Log sum pieces.
	logic [nccPkg::FracBits:0] fracSum;
	logic [3:0] expSum;
	// Mantissa shifted by the exponent sum.
	logic [nccPkg::FracBits+15:0] shifted;
	logic [15:0] product;
	logic negTerm;

	// Descriptor register of this tap.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			descOut <= '0;
		end else if (shiftDesc) begin
			descOut <= descIn;
		end
	end

	// Window register of this tap.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			winOut <= '0;
		end else if (shiftWin) begin
			winOut <= winIn;
		end
	end

	// Add the logs.
	// A fraction carry bumps the exponent.
	always_comb begin
		fracSum = {1'b0, descOut.lw.frac} + {1'b0, winOut.lw.frac};
		expSum = {1'b0, descOut.lw.exp} + {1'b0, winOut.lw.exp} +
			{3'b000, fracSum[nccPkg::FracBits]};
		// Antilog is (1.F) times 2^E with the fraction dropped.
		shifted = {15'd0, 1'b1, fracSum[nccPkg::FracBits-1:0]} << expSum;
		product = shifted[nccPkg::FracBits +: 16];
		// Only the descriptor carries a sign.
		negTerm = descOut.neg;
	end

	always_comb begin
		if (descOut.lw.zero || winOut.lw.zero) begin
			term = '0;
		end else if (negTerm) begin
			term = -$signed({1'b0, product});
		end else begin
			term = $signed({1'b0, product});
		end
	end

	// A zero operand must kill the term.
	assert property (@(posedge clk) disable iff (rst)
		(descOut.lw.zero || winOut.lw.zero) |-> term == '0);

endmodule

`default_nettype wire

// ==== rtl/logDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module logDecode (
	input logic clk,
	input logic rst,
	input logic advance,
	input nccPkg::inBeat_t inBeat,
	input logic inValid,
	output nccPkg::decoded_t dec
);

	// Magnitude picked from the payload.
	logic [7:0] mag;
	// Binary search intermediates.
	logic [3:0] upper4;
	logic [1:0] upper2;
	logic [2:0] lead;
	// Magnitude with the leading one moved to bit 7.
	logic [7:0] justified;
	nccPkg::logWord_t lwNext;
	nccPkg::decoded_t decNext;

	// ####################################################################
	// Payload decode
	// ####################################################################

	// Descriptors use the 7-bit magnitude.
	// Window pixels use the whole byte.
	always_comb begin
		if (inBeat.isDesc) begin
			mag = {1'b0, inBeat.payload.desc.mag};
		end else begin
			mag = inBeat.payload.win;
		end
	end

	// ####################################################################
	// Leading one and fraction
	// ####################################################################

	// Halve the search window at each step.
	// Top nibble first, then the top pair, then the top bit.
	always_comb begin
		lead[2] = |mag[7:4];
		upper4 = lead[2] ? mag[7:4] : mag[3:0];
		lead[1] = |upper4[3:2];
		upper2 = lead[1] ? upper4[3:2] : upper4[1:0];
		lead[0] = upper2[1];
	end

	// Shift the leading one up to bit 7.
	// Bits below it become the fraction, zero filled from below.
	assign justified = mag << (3'd7 - lead);

	always_comb begin
		lwNext.zero = (mag == 8'd0);
		lwNext.exp = lead;
		lwNext.frac = justified[6 -: nccPkg::FracBits];
	end

	always_comb begin
		decNext.valid = inValid;
		decNext.isDesc = inBeat.isDesc;
		// Only descriptors carry a sign.
		decNext.neg = inBeat.isDesc & inBeat.payload.desc.neg;
		decNext.lw = lwNext;
	end

	// ####################################################################
	// Decode register
	// ####################################################################

	// Moves only with the rest of the pipeline.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dec <= '0;
		end else if (advance) begin
			dec <= decNext;
		end
	end

	// A 7-bit descriptor magnitude never has its leading one at bit 7.
	assert property (@(posedge clk) disable iff (rst)
		dec.valid && dec.isDesc && !dec.lw.zero |-> dec.lw.exp < 3'd7);

endmodule

`default_nettype wire

// ==== rtl/nccPkg.sv ====
`default_nettype none

package nccPkg;

	// ####################################################################
	// Log word format
	// ####################################################################

	// Fraction bits kept below the leading one.
	parameter int FracBits = 5;

	// Signed descriptor pixel in sign-magnitude form.
	typedef struct packed {
		logic neg;
		logic [6:0] mag;
	} descPix_t;

	// One payload byte, read as a descriptor or as a window pixel.
	typedef union packed {
		descPix_t desc;
		logic [7:0] win;
	} pixelPayload_t;

	// Input stream beat.
	typedef struct packed {
		logic isDesc;
		pixelPayload_t payload;
	} inBeat_t;

	// Approximate base-2 log of an 8-bit magnitude.
	// exp is the leading one position.
	// frac is left justified and zero padded.
	typedef struct packed {
		logic zero;
		logic [2:0] exp;
		logic [FracBits-1:0] frac;
	} logWord_t;

	// Decode to execute word.
	// neg stays low for window beats.
	typedef struct packed {
		logic valid;
		logic isDesc;
		logic neg;
		logWord_t lw;
	} decoded_t;

	// Log operand with its sign, as it moves along the tap chain.
	typedef struct packed {
		logic neg;
		logWord_t lw;
	} tapWord_t;

endpackage

`default_nettype wire
